//--- vlog.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_array_if.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_stats.sv
verilog/dcache_top.sv
test/dcache_properties.sv
test/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := dcache_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +incdir+%,$(shell cat $(FILELIST))) verilog/dcache_defs.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

//--- test/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;
    // memory model covers the low 256 KB
    localparam int WIN_BITS = 18;
    localparam int WINDOW_LINES = 2 ** (WIN_BITS - `DC_OFFSET_BITS);
    localparam int WINDOW_WORDS = 2 ** (WIN_BITS - 2);

    typedef struct packed {
        logic we;
        addr_t addr;
        word_t wdata;
        logic miss;
        logic wb;
        addr_t wb_addr;
    } entry_t;

    logic clk_i;
    logic rst_ni;
    logic cpu_valid_i;
    logic cpu_we_i;
    addr_t cpu_addr_i;
    word_t cpu_wdata_i;
    logic cpu_ready_o;
    logic cpu_busy_o;
    word_t cpu_rdata_o;
    logic mem_valid_o;
    logic mem_we_o;
    addr_t mem_addr_o;
    line_t mem_wdata_o;
    logic mem_ready_i;
    line_t mem_rdata_i;
    count_t accesses_o;
    count_t misses_o;

    line_t mem_lines [WINDOW_LINES];
    // flat reference memory, follows every store of the table
    word_t golden [WINDOW_WORDS];
    entry_t stim [$];
    // memory requests seen since the last cpu answer
    logic log_we [$];
    addr_t log_addr [$];
    line_t log_data [$];
    logic [31:0] lfsr = 32'h0a5e_f23c;
    int errors = 0;
    int timeouts = 0;

    dcache_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // initial memory contents, every address bit matters
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h3c6e_f372;
    endfunction

    // word 0 sits in the low bits of the line
    function automatic line_t golden_line(input addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = golden[{a[WIN_BITS-1:`DC_OFFSET_BITS], 2'b00} + w];
        end
        return l;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // memory model, answers on a falling edge after 1 to 4 cycles
    initial begin
        logic busy;
        int wait_left;
        busy = 1'b0;
        wait_left = 0;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        for (int l = 0; l < WINDOW_LINES; l++) begin
            for (int w = 0; w < 4; w++) begin
                mem_lines[l][w*32 +: 32] = fill_word(addr_t'(l * 16 + w * 4));
            end
        end
        forever begin
            @(negedge clk_i);
            if (mem_ready_i) begin
                // ready is a one-cycle pulse
                mem_ready_i = 1'b0;
                busy = 1'b0;
            end else if (mem_valid_o) begin
                if (!busy) begin
                    busy = 1'b1;
                    log_we.push_back(mem_we_o);
                    log_addr.push_back(mem_addr_o);
                    log_data.push_back(mem_wdata_o);
                    if (mem_addr_o[31:WIN_BITS] != '0) begin
                        errors++;
                        $display("Memory request at %h lies outside the model window",
                                 mem_addr_o);
                    end
                    // two lfsr bits give the extra wait
                    lfsr = lfsr_step(lfsr);
                    wait_left = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                    wait_left = wait_left * 2 + lfsr[0];
                end
                if (wait_left > 0) begin
                    wait_left--;
                end else if (mem_we_o) begin
                    mem_lines[mem_addr_o[WIN_BITS-1:`DC_OFFSET_BITS]] = mem_wdata_o;
                    mem_ready_i = 1'b1;
                end else begin
                    mem_rdata_i = mem_lines[mem_addr_o[WIN_BITS-1:`DC_OFFSET_BITS]];
                    mem_ready_i = 1'b1;
                end
            end
        end
    end

    // one cpu request, then its answer, memory traffic and counters
    task automatic apply_entry(input entry_t e, input count_t n_access, input count_t n_miss);
        int cycles;
        int n_req;
        addr_t fetch_addr;
        cycles = 0;
        n_req = e.miss ? (e.wb ? 2 : 1) : 0;
        fetch_addr = {e.addr[31:`DC_OFFSET_BITS], {`DC_OFFSET_BITS{1'b0}}};
        @(negedge clk_i);
        cpu_valid_i = 1'b1;
        cpu_we_i = e.we;
        cpu_addr_i = e.addr;
        cpu_wdata_i = e.wdata;
        do begin
            @(negedge clk_i);
            cycles++;
            // every cycle before the answer is miss handling
            if (!cpu_ready_o) begin
                check_bit("cpu_busy_o", cpu_busy_o, 1'b1);
            end
        end while (!cpu_ready_o && cycles < TIMEOUT_CYCLES);
        if (!cpu_ready_o) begin
            timeouts++;
            $display("Timeout: no cpu_ready_o within %0d cycles for the request to %h",
                     TIMEOUT_CYCLES, e.addr);
            cpu_valid_i = 1'b0;
            return;
        end
        if (!e.miss) begin
            // hit answers in the cycle after the request is taken
            check_count("cpu_ready_o delay", count_t'(cycles), 1);
        end
        if (!e.we) begin
            check_word("cpu_rdata_o", cpu_rdata_o, golden[e.addr[WIN_BITS-1:2]]);
        end
        check_count("memory requests", count_t'(log_we.size()), count_t'(n_req));
        if (log_we.size() == n_req && e.wb) begin
            check_bit("write-back mem_we_o", log_we[0], 1'b1);
            check_addr("write-back mem_addr_o", log_addr[0], e.wb_addr);
            check_line("write-back mem_wdata_o", log_data[0], golden_line(e.wb_addr));
        end
        if (log_we.size() == n_req && e.miss) begin
            check_bit("fetch mem_we_o", log_we[n_req-1], 1'b0);
            check_addr("fetch mem_addr_o", log_addr[n_req-1], fetch_addr);
        end
        check_count("accesses_o", accesses_o, n_access);
        check_count("misses_o", misses_o, n_miss);
        if (e.we) begin
            golden[e.addr[WIN_BITS-1:2]] = e.wdata;
        end
        log_we.delete();
        log_addr.delete();
        log_data.delete();
        // request held through the edge that closes the ready cycle
        @(negedge clk_i);
        cpu_valid_i = 1'b0;
    endtask

    initial begin
        int misses_expected;
        misses_expected = 0;
        rst_ni = 1'b0;
        cpu_valid_i = 1'b0;
        cpu_we_i = 1'b0;
        cpu_addr_i = '0;
        cpu_wdata_i = '0;
        for (int a = 0; a < WINDOW_WORDS; a++) begin
            golden[a] = fill_word(addr_t'(a * 4));
        end
        // store, address, store data, miss, write-back, write-back address
        stim.push_back(entry_t'{1'b0, 32'h0000_1230, 32'h0, 1'b1, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_1234, 32'h0, 1'b0, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b1, 32'h0000_1238, 32'hdead_beef, 1'b0, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_1230, 32'h0, 1'b0, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_1234, 32'h0, 1'b0, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_1238, 32'h0, 1'b0, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_123c, 32'h0, 1'b0, 1'b0, 32'h0});
        // same index, new tag, dirty victim
        stim.push_back(entry_t'{1'b0, 32'h0000_5230, 32'h0, 1'b1, 1'b1, 32'h0000_1230});
        // store miss on a clean victim
        stim.push_back(entry_t'{1'b1, 32'h0000_9230, 32'h1357_2468, 1'b1, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_9230, 32'h0, 1'b0, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b1, 32'h0000_2044, 32'hcafe_f00d, 1'b1, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_2044, 32'h0, 1'b0, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_d230, 32'h0, 1'b1, 1'b1, 32'h0000_9230});
        // reload of a written-back line
        stim.push_back(entry_t'{1'b0, 32'h0000_9230, 32'h0, 1'b1, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b1, 32'h0000_9234, 32'h0bad_cafe, 1'b0, 1'b0, 32'h0});
        stim.push_back(entry_t'{1'b0, 32'h0000_5238, 32'h0, 1'b1, 1'b1, 32'h0000_9230});
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;
        // quiet outputs and cleared counters out of reset
        check_bit("cpu_ready_o", cpu_ready_o, 1'b0);
        check_bit("cpu_busy_o", cpu_busy_o, 1'b0);
        check_bit("mem_valid_o", mem_valid_o, 1'b0);
        check_count("accesses_o", accesses_o, 0);
        check_count("misses_o", misses_o, 0);
        for (int i = 0; i < stim.size() && timeouts == 0; i++) begin
            misses_expected += stim[i].miss;
            apply_entry(stim[i], count_t'(i + 1), count_t'(misses_expected));
        end
        check_count("accesses_o after table", accesses_o, count_t'(stim.size()));
        check_count("misses_o after table", misses_o, count_t'(misses_expected));
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, UUT.u_props.assert_fails);
        if (errors == 0 && timeouts == 0 && UUT.u_props.assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/dcache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_properties (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic cpu_valid_i,
    input wire logic cpu_ready_i,
    input wire logic cpu_busy_i,
    input wire logic mem_valid_i,
    input wire logic mem_we_i,
    input wire dcache_pkg::addr_t mem_addr_i,
    input wire logic mem_ready_i
);

    // number of failed assertions
    int unsigned assert_fails = 0;

    // memory request held with one address and kind until ready
    mem_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i) && $stable(mem_we_i))
    else begin
        assert_fails++;
        $error("memory request dropped or changed before mem_ready_i");
    end

    // valid drops right after the handshake
    mem_valid_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_valid_i && mem_ready_i |=> !mem_valid_i)
    else begin
        assert_fails++;
        $error("mem_valid_o still high in the cycle after mem_ready_i");
    end

    // ready only answers a live request
    cpu_ready_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cpu_ready_i |-> cpu_valid_i)
    else begin
        assert_fails++;
        $error("cpu_ready_o high without cpu_valid_i");
    end

    cpu_ready_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(cpu_ready_i && cpu_busy_i))
    else begin
        assert_fails++;
        $error("cpu_ready_o and cpu_busy_o high together");
    end

endmodule

bind dcache_top dcache_properties u_props (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cpu_valid_i(cpu_valid_i),
    .cpu_ready_i(cpu_ready_o),
    .cpu_busy_i (cpu_busy_o),
    .mem_valid_i(mem_valid_o),
    .mem_we_i   (mem_we_o),
    .mem_addr_i (mem_addr_o),
    .mem_ready_i(mem_ready_i)
);

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input wire logic clk_i,
    input wire logic rst_ni,
    // cpu side
    input wire logic cpu_valid_i,
    input wire logic cpu_we_i,
    input wire dcache_pkg::addr_t cpu_addr_i,
    input wire dcache_pkg::word_t cpu_wdata_i,
    output logic cpu_ready_o,
    output logic cpu_busy_o,
    output dcache_pkg::word_t cpu_rdata_o,
    // memory side
    output logic mem_valid_o,
    output logic mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o,
    input wire logic mem_ready_i,
    input wire dcache_pkg::line_t mem_rdata_i,
    // statistics
    output dcache_pkg::count_t accesses_o,
    output dcache_pkg::count_t misses_o
);

    // controller to array bundle
    dcache_array_if arr_if ();

    // event pulses into the counters
    logic access;
    logic miss;

    dcache_tag_array u_tag_array (
        .clk_i (clk_i),
        .rst_ni(rst_ni),
        .arr   (arr_if.array)
    );

    dcache_data_array u_data_array (
        .clk_i(clk_i),
        .arr  (arr_if.array)
    );

    dcache_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .cpu_valid_i(cpu_valid_i),
        .cpu_we_i   (cpu_we_i),
        .cpu_addr_i (cpu_addr_i),
        .cpu_wdata_i(cpu_wdata_i),
        .cpu_ready_o(cpu_ready_o),
        .cpu_busy_o (cpu_busy_o),
        .cpu_rdata_o(cpu_rdata_o),
        .mem_valid_o(mem_valid_o),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_wdata_o(mem_wdata_o),
        .mem_ready_i(mem_ready_i),
        .mem_rdata_i(mem_rdata_i),
        .arr        (arr_if.ctrl),
        .access_o   (access),
        .miss_o     (miss)
    );

    dcache_stats u_stats (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .access_i  (access),
        .miss_i    (miss),
        .accesses_o(accesses_o),
        .misses_o  (misses_o)
    );

endmodule

`default_nettype wire

//--- verilog/dcache_stats.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_stats (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic access_i,
    input wire logic miss_i,
    output dcache_pkg::count_t accesses_o,
    output dcache_pkg::count_t misses_o
);
    import dcache_pkg::*;

    count_t accesses_q;
    count_t misses_q;

    // one count per accepted request
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            accesses_q <= '0;
        end else if (access_i) begin
            accesses_q <= accesses_q + 1'b1;
        end
    end

    // one count per missing compare
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            misses_q <= '0;
        end else if (miss_i) begin
            misses_q <= misses_q + 1'b1;
        end
    end

    // hits are accesses minus misses
    assign accesses_o = accesses_q;
    assign misses_o   = misses_q;

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl (
    input wire logic clk_i,
    input wire logic rst_ni,
    // cpu side
    input wire logic cpu_valid_i,
    input wire logic cpu_we_i,
    input wire dcache_pkg::addr_t cpu_addr_i,
    input wire dcache_pkg::word_t cpu_wdata_i,
    output logic cpu_ready_o,
    output logic cpu_busy_o,
    output dcache_pkg::word_t cpu_rdata_o,
    // memory side
    output logic mem_valid_o,
    output logic mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o,
    input wire logic mem_ready_i,
    input wire dcache_pkg::line_t mem_rdata_i,
    // arrays
    dcache_array_if.ctrl arr,
    // event pulses to the counters
    output logic access_o,
    output logic miss_o
);
    import dcache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // address fields of the current request
    tag_t addr_tag;
    index_t index;
    logic [`DC_OFFSET_BITS-3:0] word_sel;

    logic hit;
    logic victim_dirty;
    logic mem_done;
    line_t merged_line;
    addr_t line_addr;

    // request towards memory
    logic mem_valid_q;
    addr_t wb_addr_q;

    assign addr_tag = cpu_addr_i[`DC_TAG_LSB +: `DC_TAG_BITS];
    assign index    = cpu_addr_i[`DC_INDEX_LSB +: `DC_INDEX_BITS];
    assign word_sel = cpu_addr_i[`DC_WORD_SEL_LSB +: `DC_OFFSET_BITS-2];

    // both arrays always look at the request's line
    assign arr.index = index;

    assign hit          = arr.valid_rdata && (arr.tag_rdata == addr_tag);
    assign victim_dirty = arr.valid_rdata && arr.dirty_rdata;

    // ready only counts while a request is out
    assign mem_done = mem_valid_q && mem_ready_i;

    // line-aligned fetch address
    assign line_addr = {addr_tag, index, {`DC_OFFSET_BITS{1'b0}}};

    // addressed word out of the stored line
    assign cpu_rdata_o = arr.data_rdata[word_sel * $bits(word_t) +: $bits(word_t)];

    // store word dropped into the stored line
    always_comb begin
        merged_line = arr.data_rdata;
        merged_line[word_sel * $bits(word_t) +: $bits(word_t)] = cpu_wdata_i;
    end

    always_comb begin
        state_d = state_q;
        cpu_ready_o = 1'b0;
        cpu_busy_o = 1'b0;
        access_o = 1'b0;
        miss_o = 1'b0;
        // default write values are those of a store hit
        arr.tag_we = 1'b0;
        arr.tag_wdata = addr_tag;
        arr.valid_wdata = 1'b1;
        arr.dirty_wdata = 1'b1;
        arr.data_we = 1'b0;
        arr.data_wdata = merged_line;

        case (state_q)
            IDLE: begin
                if (cpu_valid_i) begin
                    access_o = 1'b1;
                    state_d = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                if (hit) begin
                    cpu_ready_o = 1'b1;
                    state_d = IDLE;
                    // store hit, merge word and mark line dirty
                    if (cpu_we_i) begin
                        arr.data_we = 1'b1;
                        arr.tag_we = 1'b1;
                    end
                end else begin
                    miss_o = 1'b1;
                    cpu_busy_o = 1'b1;
                    // dirty victim goes out first
                    state_d = victim_dirty ? WRITE_BACK : ALLOCATE;
                end
            end
            WRITE_BACK: begin
                cpu_busy_o = 1'b1;
                if (mem_done) begin
                    state_d = ALLOCATE;
                end
            end
            ALLOCATE: begin
                cpu_busy_o = 1'b1;
                if (mem_done) begin
                    // fetched line lands clean, store merge on the second compare
                    arr.data_we = 1'b1;
                    arr.data_wdata = mem_rdata_i;
                    arr.tag_we = 1'b1;
                    arr.dirty_wdata = 1'b0;
                    state_d = COMPARE_TAG;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // mem valid drops for one cycle after each ready
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            mem_valid_q <= 1'b0;
        end else begin
            case (state_q)
                COMPARE_TAG: mem_valid_q <= !hit;
                WRITE_BACK, ALLOCATE: mem_valid_q <= !mem_done;
                default: mem_valid_q <= 1'b0;
            endcase
        end
    end

    // victim address, old tag joined with the index
    always_ff @(posedge clk_i) begin
        if (state_q == COMPARE_TAG) begin
            wb_addr_q <= {arr.tag_rdata, index, {`DC_OFFSET_BITS{1'b0}}};
        end
    end

    assign mem_valid_o = mem_valid_q;
    assign mem_we_o    = (state_q == WRITE_BACK);
    assign mem_addr_o  = (state_q == WRITE_BACK) ? wb_addr_q : line_addr;
    // victim line still in the array until allocate writes over it
    assign mem_wdata_o = arr.data_rdata;

endmodule

`default_nettype wire

//--- verilog/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_data_array (
    input wire logic clk_i,
    dcache_array_if.array arr
);
    import dcache_pkg::*;

    // line storage
    line_t lines [`DC_LINES];

    // whole line written at the edge, word merge is done upstream
    always_ff @(posedge clk_i) begin
        if (arr.data_we) begin
            lines[arr.index] <= arr.data_wdata;
        end
    end

    // combinational read of the indexed line
    assign arr.data_rdata = lines[arr.index];

endmodule

`default_nettype wire

//--- verilog/dcache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag_array (
    input wire logic clk_i,
    input wire logic rst_ni,
    dcache_array_if.array arr
);
    import dcache_pkg::*;

    // one tag per line
    tag_t tags [`DC_LINES];

    // status bits kept as flat vectors so reset can clear them at once
    logic [`DC_LINES-1:0] valid_q;
    logic [`DC_LINES-1:0] dirty_q;

    // tag storage, payload only
    always_ff @(posedge clk_i) begin
        if (arr.tag_we) begin
            tags[arr.index] <= arr.tag_wdata;
        end
    end

    // valid and dirty, cleared on reset
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.tag_we) begin
            // tag, valid and dirty always replaced together
            valid_q[arr.index] <= arr.valid_wdata;
            dirty_q[arr.index] <= arr.dirty_wdata;
        end
    end

    // read straight from the index, no latency
    assign arr.tag_rdata   = tags[arr.index];
    assign arr.valid_rdata = valid_q[arr.index];
    assign arr.dirty_rdata = dirty_q[arr.index];

endmodule

`default_nettype wire

//--- verilog/dcache_array_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if;
    import dcache_pkg::*;

    // shared line select for both arrays
    index_t index;
    // tag array write side
    logic tag_we;
    tag_t tag_wdata;
    logic valid_wdata;
    logic dirty_wdata;
    // data array write side
    logic data_we;
    line_t data_wdata;
    // combinational read results
    tag_t tag_rdata;
    logic valid_rdata;
    logic dirty_rdata;
    line_t data_rdata;

    modport ctrl (
        output index, tag_we, tag_wdata, valid_wdata, dirty_wdata, data_we, data_wdata,
        input tag_rdata, valid_rdata, dirty_rdata, data_rdata
    );

    modport array (
        input index, tag_we, tag_wdata, valid_wdata, dirty_wdata, data_we, data_wdata,
        output tag_rdata, valid_rdata, dirty_rdata, data_rdata
    );

endinterface

`default_nettype wire

//--- verilog/dcache_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

    // byte address from the cpu
    typedef logic [`DC_ADDR_BITS-1:0] addr_t;

    // one cpu data word
    typedef logic [31:0] word_t;

    // one cache line, also one memory transfer
    typedef logic [`DC_LINE_BITS-1:0] line_t;

    // stored tag and line index
    typedef logic [`DC_TAG_BITS-1:0] tag_t;
    typedef logic [`DC_INDEX_BITS-1:0] index_t;

    // statistics counter, wraps
    typedef logic [31:0] count_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        COMPARE_TAG,
        WRITE_BACK,
        ALLOCATE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// byte address and line widths
`define DC_ADDR_BITS 32
`define DC_LINE_BITS 128

// address split of a direct-mapped cache, 1024 lines of 16 bytes
`define DC_OFFSET_BITS 4
`define DC_INDEX_BITS 10
`define DC_TAG_BITS 18
`define DC_LINES 1024

// field positions inside the byte address
`define DC_WORD_SEL_LSB 2
`define DC_INDEX_LSB 4
`define DC_TAG_LSB 14

`endif
